// File: design/vga_pkg.sv
package vga_pkg;

    // graphics mode register encoding
    typedef enum logic [1:0] {
        MODE_OFF          = 2'b00,
        MODE_TEXT_40      = 2'b01,
        MODE_GRAPHICS_640 = 2'b10,
        MODE_GRAPHICS_320 = 2'b11
    } vga_mode_e;

    // palette update word
    // the bus side fills it byte by byte, the palette reads the fields
    typedef union packed {
        logic [3:0][7:0] bytes;
        struct packed {
            logic [7:0] index;
            logic [7:0] red;
            logic [7:0] green;
            logic [7:0] blue;
        } entry;
    } palette_update_u;

    // external RAM geometry, word addressed
    localparam int RAM_ADR_W = 18;
    localparam int RAM_DAT_W = 16;

    // base addresses after reset, in words
    localparam logic [RAM_ADR_W-1:0] RAM_BASE_RESET = RAM_ADR_W'(128 * 1024);
    // 256K words does not fit in 18 bits and wraps to zero
    localparam logic [RAM_ADR_W-1:0] FONT_BASE_RESET = RAM_ADR_W'(256 * 1024);

    // clocks from counter position to RGB at the pins
    // one for the index register in fetch, one for the colour register
    localparam int PIPE_DELAY = 2;

    // scan line counter width
    localparam int ROW_W = 10;

endpackage

// File: design/vga_ctrl_if.sv
`timescale 1ns/10ps

interface vga_ctrl_if import vga_pkg::*; ();

    // set by the register bank
    vga_mode_e              mode;
    logic [RAM_ADR_W-1:0]   ram_base;

    // scan line status from the timing generator
    logic [ROW_W-1:0]       row;
    logic                   row_visible;

    modport regs (
        output mode,
        output ram_base,
        input  row,
        input  row_visible
    );

    modport timing (
        output row,
        output row_visible
    );

    modport fetch (
        input mode,
        input ram_base
    );

endinterface

// File: design/vga_wb8_regs.sv
`timescale 1ns/10ps

module vga_wb8_regs import vga_pkg::*; (
    input  logic            I_wb_clk,
    input  logic            I_reset,
    input  logic [12:0]     I_wb_adr,
    input  logic [7:0]      I_wb_dat,
    input  logic            I_wb_stb,
    input  logic            I_wb_we,
    output logic            O_wb_ack,
    output logic [7:0]      O_wb_dat,
    output logic            pal_req,
    input  logic            pal_ack,
    output palette_update_u pal_entry,
    vga_ctrl_if.regs        ctrl
);

    logic [23:0]          addr_stage;
    logic [RAM_ADR_W-1:0] font_base;
    logic [1:0]           row_hi;
    logic [23:0]          ram_byte_adr;
    logic [23:0]          font_byte_adr;
    logic                 wr_en;
    logic                 rd_en;

    assign wr_en = I_wb_stb && I_wb_we;
    assign rd_en = I_wb_stb && !I_wb_we;

    // bases are word addresses, software sees byte addresses
    assign ram_byte_adr  = 24'({ctrl.ram_base, 1'b0});
    assign font_byte_adr = 24'({font_base, 1'b0});

    always_ff @(posedge I_wb_clk) begin
        if (I_reset) begin
            O_wb_ack      <= 1'b0;
            pal_req       <= 1'b0;
            ctrl.mode     <= MODE_OFF;
            ctrl.ram_base <= RAM_BASE_RESET;
            font_base     <= FONT_BASE_RESET;
        end else begin
            O_wb_ack <= I_wb_stb;
            if (wr_en) begin
                case (I_wb_adr[3:0])
                    // commit drops the byte offset bit
                    4'h3: ctrl.ram_base <= addr_stage[RAM_ADR_W:1];
                    4'h7: font_base     <= addr_stage[RAM_ADR_W:1];
                    // request by making req differ from ack
                    4'hB: pal_req       <= !pal_ack;
                    4'hF: ctrl.mode     <= vga_mode_e'(I_wb_dat[1:0]);
                    default: begin
                    end
                endcase
            end
        end
    end

    // staging bytes and read data
    always_ff @(posedge I_wb_clk) begin
        if (wr_en) begin
            case (I_wb_adr[3:0])
                4'h0, 4'h4: addr_stage[7:0]   <= I_wb_dat;
                4'h1, 4'h5: addr_stage[15:8]  <= I_wb_dat;
                4'h2, 4'h6: addr_stage[23:16] <= I_wb_dat;
                // blue, green, red, then the entry index
                4'h8: pal_entry.bytes[0] <= I_wb_dat;
                4'h9: pal_entry.bytes[1] <= I_wb_dat;
                4'hA: pal_entry.bytes[2] <= I_wb_dat;
                4'hB: pal_entry.bytes[3] <= I_wb_dat;
                default: begin
                end
            endcase
        end
        if (rd_en) begin
            case (I_wb_adr[3:0])
                4'h0: O_wb_dat <= ram_byte_adr[7:0];
                4'h1: O_wb_dat <= ram_byte_adr[15:8];
                4'h2: O_wb_dat <= ram_byte_adr[23:16];
                4'h4: O_wb_dat <= font_byte_adr[7:0];
                4'h5: O_wb_dat <= font_byte_adr[15:8];
                4'h6: O_wb_dat <= font_byte_adr[23:16];
                4'h8: O_wb_dat <= pal_entry.bytes[0];
                4'h9: O_wb_dat <= pal_entry.bytes[1];
                4'hA: O_wb_dat <= pal_entry.bytes[2];
                4'hB: O_wb_dat <= pal_entry.bytes[3];
                // high row bits are frozen so C then D gives one consistent row
                4'hC: begin
                    O_wb_dat <= ctrl.row[7:0];
                    row_hi   <= ctrl.row[9:8];
                end
                4'hD: O_wb_dat <= {6'b000000, row_hi};
                4'hE: O_wb_dat <= {7'b0000000, ctrl.row_visible};
                4'hF: O_wb_dat <= {6'b000000, ctrl.mode};
                default: O_wb_dat <= 8'h00;
            endcase
        end
    end

    // the palette must have taken the previous update before a new toggle
    pal_req_idle: assert property (@(posedge I_wb_clk) disable iff (I_reset)
        (wr_en && I_wb_adr[3:0] == 4'hB) |-> (pal_req == pal_ack));

endmodule

// File: design/vga_timing.sv
`timescale 1ns/10ps

module vga_timing import vga_pkg::*; #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33,
    localparam int H_TOTAL  = H_VISIBLE + H_FRONT + H_SYNC + H_BACK,
    localparam int H_W      = $clog2(H_TOTAL)
) (
    input  logic             I_wb_clk,
    input  logic             I_reset,
    output logic [H_W-1:0]   h_count,
    output logic [ROW_W-1:0] v_count,
    output logic             active,
    output logic             O_vga_hsync,
    output logic             O_vga_vsync,
    vga_ctrl_if.timing       ctrl
);

    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    logic                  hsync_now;
    logic                  vsync_now;
    logic [PIPE_DELAY-1:0] hsync_pipe;
    logic [PIPE_DELAY-1:0] vsync_pipe;

    always_ff @(posedge I_wb_clk) begin
        if (I_reset) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == H_W'(H_TOTAL - 1)) begin
            h_count <= '0;
            if (v_count == ROW_W'(V_TOTAL - 1)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    assign active = (h_count < H_VISIBLE) && (v_count < V_VISIBLE);

    // sync intervals follow visible area plus front porch
    assign hsync_now = (h_count >= H_VISIBLE + H_FRONT) &&
                       (h_count < H_VISIBLE + H_FRONT + H_SYNC);
    assign vsync_now = (v_count >= V_VISIBLE + V_FRONT) &&
                       (v_count < V_VISIBLE + V_FRONT + V_SYNC);

    // delay syncs to line up with the RGB pipeline
    always_ff @(posedge I_wb_clk) begin
        if (I_reset) begin
            hsync_pipe <= '0;
            vsync_pipe <= '0;
        end else begin
            hsync_pipe <= {hsync_pipe[PIPE_DELAY-2:0], hsync_now};
            vsync_pipe <= {vsync_pipe[PIPE_DELAY-2:0], vsync_now};
        end
    end

    assign O_vga_hsync = hsync_pipe[PIPE_DELAY-1];
    assign O_vga_vsync = vsync_pipe[PIPE_DELAY-1];

    assign ctrl.row         = v_count;
    assign ctrl.row_visible = v_count < V_VISIBLE;

    hsync_outside_visible: assert property (@(posedge I_wb_clk) disable iff (I_reset)
        O_vga_hsync |-> $past(h_count, PIPE_DELAY) >= H_VISIBLE);

endmodule

// File: design/vga_pixel_fetch.sv
`timescale 1ns/10ps

module vga_pixel_fetch import vga_pkg::*; #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    localparam int H_TOTAL  = H_VISIBLE + H_FRONT + H_SYNC + H_BACK,
    localparam int H_W      = $clog2(H_TOTAL)
) (
    input  logic                 I_wb_clk,
    input  logic                 I_reset,
    input  logic [H_W-1:0]       h_count,
    input  logic [ROW_W-1:0]     v_count,
    input  logic                 active,
    input  logic [RAM_DAT_W-1:0] I_ram_dat,
    output logic [RAM_ADR_W-1:0] O_ram_adr,
    output logic                 O_ram_req,
    output logic [7:0]           pix_index,
    output logic                 pix_blank,
    vga_ctrl_if.fetch            ctrl
);

    localparam int WORDS_640 = H_VISIBLE / 2;
    localparam int WORDS_320 = H_VISIBLE / 4;

    logic [H_W:0]           h_ahead_sum;
    logic                   line_wrap;
    logic [H_W-1:0]         h_ahead;
    logic [ROW_W-1:0]       v_ahead;
    logic                   ahead_visible;
    logic                   word_start;
    logic                   graphics_on;
    logic [RAM_ADR_W-1:0]   line_offset;
    logic [RAM_ADR_W-1:0]   word_offset;
    logic                   req_d;
    logic [RAM_DAT_W-1:0]   prefetch_word;
    logic                   odd_pixel;

    // look PIPE_DELAY pixels ahead, the RAM answers one clock after the request
    assign h_ahead_sum = {1'b0, h_count} + (H_W + 1)'(PIPE_DELAY);
    assign line_wrap   = h_ahead_sum >= H_TOTAL;
    assign h_ahead     = line_wrap ? H_W'(h_ahead_sum - H_TOTAL) : h_ahead_sum[H_W-1:0];

    // the line after any blanking line may be line 0 of the next frame,
    // so its first word is fetched at the end of every such line
    always_comb begin
        if (!line_wrap) begin
            v_ahead = v_count;
        end else if (v_count >= V_VISIBLE - 1) begin
            v_ahead = '0;
        end else begin
            v_ahead = v_count + 1'b1;
        end
    end

    assign ahead_visible = (h_ahead < H_VISIBLE) && (line_wrap || v_count < V_VISIBLE);

    assign graphics_on = (ctrl.mode == MODE_GRAPHICS_640) ||
                         (ctrl.mode == MODE_GRAPHICS_320);

    always_comb begin
        word_start  = 1'b0;
        line_offset = '0;
        word_offset = '0;
        case (ctrl.mode)
            // two pixels per word
            MODE_GRAPHICS_640: begin
                word_start  = !h_ahead[0];
                line_offset = RAM_ADR_W'(v_ahead * WORDS_640);
                word_offset = RAM_ADR_W'(h_ahead[H_W-1:1]);
            end
            // doubled pixels, one word spans four clocks and two lines share it
            MODE_GRAPHICS_320: begin
                word_start  = h_ahead[1:0] == 2'b00;
                line_offset = RAM_ADR_W'(v_ahead[ROW_W-1:1] * WORDS_320);
                word_offset = RAM_ADR_W'(h_ahead[H_W-1:2]);
            end
            default: begin
            end
        endcase
    end

    assign O_ram_req = ahead_visible && word_start;
    assign O_ram_adr = ctrl.ram_base + line_offset + word_offset;

    always_ff @(posedge I_wb_clk) begin
        if (I_reset) begin
            req_d     <= 1'b0;
            pix_blank <= 1'b1;
        end else begin
            req_d     <= O_ram_req;
            pix_blank <= !(active && graphics_on);
        end
    end

    always_ff @(posedge I_wb_clk) begin
        if (req_d) begin
            prefetch_word <= I_ram_dat;
        end
    end

    // low byte is the left pixel
    assign odd_pixel = (ctrl.mode == MODE_GRAPHICS_320) ? h_count[1] : h_count[0];

    always_ff @(posedge I_wb_clk) begin
        pix_index <= odd_pixel ? prefetch_word[15:8] : prefetch_word[7:0];
    end

    off_mode_quiet: assert property (@(posedge I_wb_clk) disable iff (I_reset)
        (ctrl.mode == MODE_OFF) |-> !O_ram_req ##1 pix_blank);

endmodule

// File: design/vga_palette.sv
`timescale 1ns/10ps

module vga_palette import vga_pkg::*; (
    input  logic            I_wb_clk,
    input  logic            I_reset,
    input  logic [7:0]      pix_index,
    input  logic            pix_blank,
    input  logic            pal_req,
    input  palette_update_u pal_entry,
    output logic            pal_ack,
    output logic [7:0]      O_vga_r,
    output logic [7:0]      O_vga_g,
    output logic [7:0]      O_vga_b
);

    logic [23:0] colour_mem [0:255];
    logic        update_pending;
    logic [23:0] colour;

    // toggle handshake, pending while req and ack differ
    assign update_pending = pal_req != pal_ack;

    always_ff @(posedge I_wb_clk) begin
        if (update_pending) begin
            colour_mem[pal_entry.entry.index] <= {pal_entry.entry.red,
                                                  pal_entry.entry.green,
                                                  pal_entry.entry.blue};
        end
    end

    always_ff @(posedge I_wb_clk) begin
        if (I_reset) begin
            pal_ack <= 1'b0;
        end else begin
            pal_ack <= pal_req;
        end
    end

    assign colour = colour_mem[pix_index];

    // second pipeline stage, black outside the picture
    always_ff @(posedge I_wb_clk) begin
        if (I_reset || pix_blank) begin
            {O_vga_r, O_vga_g, O_vga_b} <= 24'h000000;
        end else begin
            {O_vga_r, O_vga_g, O_vga_b} <= colour;
        end
    end

endmodule

// File: design/vga_wb8_extram.sv
`timescale 1ns/10ps

module vga_wb8_extram import vga_pkg::*; #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    // wishbone
    input  logic                 I_wb_clk,
    input  logic                 I_reset,
    input  logic [12:0]          I_wb_adr,
    input  logic [7:0]           I_wb_dat,
    input  logic                 I_wb_stb,
    input  logic                 I_wb_we,
    output logic                 O_wb_ack,
    output logic [7:0]           O_wb_dat,
    // external RAM
    output logic [RAM_ADR_W-1:0] O_ram_adr,
    output logic                 O_ram_req,
    input  logic [RAM_DAT_W-1:0] I_ram_dat,
    // VGA
    output logic                 O_vga_hsync,
    output logic                 O_vga_vsync,
    output logic [7:0]           O_vga_r,
    output logic [7:0]           O_vga_g,
    output logic [7:0]           O_vga_b
);

    localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int H_W     = $clog2(H_TOTAL);

    logic [H_W-1:0]   h_count;
    logic [ROW_W-1:0] v_count;
    logic             active;
    logic [7:0]       pix_index;
    logic             pix_blank;
    logic             pal_req;
    logic             pal_ack;
    palette_update_u  pal_entry;

    vga_ctrl_if ctrl ();

    vga_wb8_regs i_vga_wb8_regs (
        .I_wb_clk  (I_wb_clk),
        .I_reset   (I_reset),
        .I_wb_adr  (I_wb_adr),
        .I_wb_dat  (I_wb_dat),
        .I_wb_stb  (I_wb_stb),
        .I_wb_we   (I_wb_we),
        .O_wb_ack  (O_wb_ack),
        .O_wb_dat  (O_wb_dat),
        .pal_req   (pal_req),
        .pal_ack   (pal_ack),
        .pal_entry (pal_entry),
        .ctrl      (ctrl.regs)
    );

    vga_timing #(
        .H_VISIBLE (H_VISIBLE),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .V_VISIBLE (V_VISIBLE),
        .V_FRONT   (V_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK)
    ) i_vga_timing (
        .I_wb_clk    (I_wb_clk),
        .I_reset     (I_reset),
        .h_count     (h_count),
        .v_count     (v_count),
        .active      (active),
        .O_vga_hsync (O_vga_hsync),
        .O_vga_vsync (O_vga_vsync),
        .ctrl        (ctrl.timing)
    );

    vga_pixel_fetch #(
        .H_VISIBLE (H_VISIBLE),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .V_VISIBLE (V_VISIBLE)
    ) i_vga_pixel_fetch (
        .I_wb_clk  (I_wb_clk),
        .I_reset   (I_reset),
        .h_count   (h_count),
        .v_count   (v_count),
        .active    (active),
        .I_ram_dat (I_ram_dat),
        .O_ram_adr (O_ram_adr),
        .O_ram_req (O_ram_req),
        .pix_index (pix_index),
        .pix_blank (pix_blank),
        .ctrl      (ctrl.fetch)
    );

    vga_palette i_vga_palette (
        .I_wb_clk  (I_wb_clk),
        .I_reset   (I_reset),
        .pix_index (pix_index),
        .pix_blank (pix_blank),
        .pal_req   (pal_req),
        .pal_entry (pal_entry),
        .pal_ack   (pal_ack),
        .O_vga_r   (O_vga_r),
        .O_vga_g   (O_vga_g),
        .O_vga_b   (O_vga_b)
    );

endmodule

// File: bench/tb_vga_wb8_extram.sv
`timescale 1ns/10ps

module tb_vga_wb8_extram import vga_pkg::*; ();

    // tiny frame, 24 clocks per line and 13 lines
    localparam int H_VISIBLE = 16;
    localparam int H_FRONT   = 2;
    localparam int H_SYNC    = 3;
    localparam int H_BACK    = 3;
    localparam int V_VISIBLE = 8;
    localparam int V_FRONT   = 1;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 2;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    localparam int ACK_TIMEOUT  = 8;
    localparam int SYNC_TIMEOUT = 1000;
    localparam int NUM_OPS      = 38;
    localparam int NUM_FRAMES   = 3;

    typedef struct packed {
        logic       we;
        logic [3:0] adr;
        logic [7:0] dat;
        logic [7:0] expected;
    } reg_op_t;

    typedef struct packed {
        logic [1:0]           mode;
        logic [RAM_ADR_W-1:0] base;
    } frame_t;

    logic                 I_wb_clk = 1'b0;
    logic                 I_reset;
    logic [12:0]          I_wb_adr;
    logic [7:0]           I_wb_dat;
    logic                 I_wb_stb;
    logic                 I_wb_we;
    logic                 O_wb_ack;
    logic [7:0]           O_wb_dat;
    logic [RAM_ADR_W-1:0] O_ram_adr;
    logic                 O_ram_req;
    logic [RAM_DAT_W-1:0] I_ram_dat;
    logic                 O_vga_hsync;
    logic                 O_vga_vsync;
    logic [7:0]           O_vga_r;
    logic [7:0]           O_vga_g;
    logic [7:0]           O_vga_b;

    reg_op_t      reg_ops [0:NUM_OPS-1];
    frame_t       frames [0:NUM_FRAMES-1];
    logic [15:0]  ram_words [0:255];
    logic [23:0]  pal_model [0:255];
    logic [16:0]  lfsr = 17'd67378;
    int           errors = 0;
    int           checks = 0;
    int           tests = 0;
    int           failed_tests = 0;
    int           req_count = 0;

    vga_wb8_extram #(
        .H_VISIBLE (H_VISIBLE),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .V_VISIBLE (V_VISIBLE),
        .V_FRONT   (V_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK)
    ) i_vga_wb8_extram (
        .I_wb_clk    (I_wb_clk),
        .I_reset     (I_reset),
        .I_wb_adr    (I_wb_adr),
        .I_wb_dat    (I_wb_dat),
        .I_wb_stb    (I_wb_stb),
        .I_wb_we     (I_wb_we),
        .O_wb_ack    (O_wb_ack),
        .O_wb_dat    (O_wb_dat),
        .O_ram_adr   (O_ram_adr),
        .O_ram_req   (O_ram_req),
        .I_ram_dat   (I_ram_dat),
        .O_vga_hsync (O_vga_hsync),
        .O_vga_vsync (O_vga_vsync),
        .O_vga_r     (O_vga_r),
        .O_vga_g     (O_vga_g),
        .O_vga_b     (O_vga_b)
    );

    always #10 I_wb_clk = !I_wb_clk;

    // RAM answers one clock after the request
    always @(posedge I_wb_clk) begin
        if (O_ram_req) begin
            I_ram_dat <= ram_word(O_ram_adr);
            req_count <= req_count + 1;
        end
    end

    // x^17 + x^14
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    function automatic logic [23:0] random_bits(input int n);
        logic [23:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[22:0], lfsr[0]};
        end
        return v;
    endfunction

    // upper address bits fold into the low bits of the table word
    function automatic logic [15:0] ram_word(input logic [RAM_ADR_W-1:0] adr);
        return ram_words[adr[7:0]] ^ {6'b000000, adr[17:8]};
    endfunction

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        int n;
        n = errors - errs_before;
        tests++;
        if (n > 0) begin
            failed_tests++;
        end
        $display("%s finished with %0d errors", name, n);
    endtask

    // one strobe cycle, then wait for the ack
    task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [7:0] wdat,
                             output logic [7:0] rdat);
        int cycles;
        logic ack_seen;
        I_wb_adr <= {9'h000, adr};
        I_wb_dat <= wdat;
        I_wb_we  <= we;
        I_wb_stb <= 1'b1;
        @(posedge I_wb_clk);
        I_wb_stb <= 1'b0;
        I_wb_we  <= 1'b0;
        cycles = 0;
        ack_seen = 1'b0;
        while (!ack_seen && cycles < ACK_TIMEOUT) begin
            @(posedge I_wb_clk);
            ack_seen = O_wb_ack;
            cycles++;
        end
        if (!ack_seen) begin
            abort_run("bus access got no O_wb_ack in time");
        end else begin
            rdat = O_wb_dat;
        end
    endtask

    task automatic wait_sync_fall(input logic vertical);
        logic prev_level;
        logic level;
        logic fell;
        int cycles;
        prev_level = vertical ? O_vga_vsync : O_vga_hsync;
        fell = 1'b0;
        cycles = 0;
        while (!fell && cycles < SYNC_TIMEOUT) begin
            @(posedge I_wb_clk);
            level = vertical ? O_vga_vsync : O_vga_hsync;
            fell = prev_level && !level;
            prev_level = level;
            cycles++;
        end
        if (!fell) begin
            abort_run("sync pulse never ended, the video timing looks stuck");
        end
    endtask

    task automatic run_reg_ops(input int first, input int last);
        int i;
        logic [7:0] rd;
        for (i = first; i <= last; i++) begin
            bus_cycle(reg_ops[i].we, reg_ops[i].adr, reg_ops[i].dat, rd);
            if (!reg_ops[i].we) begin
                compare($sformatf("O_wb_dat reg %h", reg_ops[i].adr), rd,
                        reg_ops[i].expected);
            end
        end
    endtask

    // blue, green and red staging bytes
    task automatic stage_colour(input logic [23:0] colour);
        logic [7:0] rd;
        bus_cycle(1'b1, 4'h8, colour[7:0], rd);
        bus_cycle(1'b1, 4'h9, colour[15:8], rd);
        bus_cycle(1'b1, 4'hA, colour[23:16], rd);
    endtask

    task automatic load_palette();
        int i;
        logic [23:0] colour;
        logic [7:0] rd;
        for (i = 0; i < 256; i++) begin
            colour = random_bits(24);
            stage_colour(colour);
            bus_cycle(1'b1, 4'hB, 8'(i), rd);
            pal_model[i] = colour;
        end
    endtask

    // base goes in as a byte address, register 3 commits it
    task automatic set_frame(input logic [1:0] mode, input logic [RAM_ADR_W-1:0] base);
        logic [23:0] byte_adr;
        logic [7:0] rd;
        byte_adr = 24'({base, 1'b0});
        bus_cycle(1'b1, 4'h0, byte_adr[7:0], rd);
        bus_cycle(1'b1, 4'h1, byte_adr[15:8], rd);
        bus_cycle(1'b1, 4'h2, byte_adr[23:16], rd);
        bus_cycle(1'b1, 4'h3, 8'h00, rd);
        bus_cycle(1'b1, 4'hF, {6'b000000, mode}, rd);
    endtask

    task automatic check_frame(input logic [1:0] mode, input logic [RAM_ADR_W-1:0] base);
        int x;
        int y;
        int reqs_before;
        logic [RAM_ADR_W-1:0] adr;
        logic [15:0] word;
        logic [7:0] idx;
        logic [23:0] expected;
        logic graphics;
        graphics = (mode == MODE_GRAPHICS_640) || (mode == MODE_GRAPHICS_320);
        reqs_before = req_count;
        wait_sync_fall(1'b1);
        // the last back porch line leads into line 0
        repeat (V_BACK - 1) wait_sync_fall(1'b0);
        for (y = 0; y < V_VISIBLE; y++) begin
            wait_sync_fall(1'b0);
            repeat (H_BACK) @(posedge I_wb_clk);
            for (x = 0; x < H_VISIBLE; x++) begin
                if (mode == MODE_GRAPHICS_320) begin
                    adr = base + RAM_ADR_W'((y / 2) * (H_VISIBLE / 4) + x / 4);
                    word = ram_word(adr);
                    idx = ((x / 2) % 2 == 1) ? word[15:8] : word[7:0];
                end else begin
                    adr = base + RAM_ADR_W'(y * (H_VISIBLE / 2) + x / 2);
                    word = ram_word(adr);
                    idx = (x % 2 == 1) ? word[15:8] : word[7:0];
                end
                expected = graphics ? pal_model[idx] : 24'h000000;
                compare($sformatf("O_vga_r/g/b x%0d y%0d", x, y),
                        {O_vga_r, O_vga_g, O_vga_b}, expected);
                @(posedge I_wb_clk);
            end
        end
        if (!graphics) begin
            wait_sync_fall(1'b1);
            compare("O_ram_req pulses", req_count - reqs_before, 0);
        end
    endtask

    task automatic fill_tables();
        int i;
        // reset readback
        reg_ops[0]  = {1'b0, 4'hF, 8'h00, 8'h00};
        reg_ops[1]  = {1'b0, 4'h0, 8'h00, 8'h00};
        reg_ops[2]  = {1'b0, 4'h1, 8'h00, 8'h00};
        reg_ops[3]  = {1'b0, 4'h2, 8'h00, 8'h04};
        reg_ops[4]  = {1'b0, 4'h4, 8'h00, 8'h00};
        reg_ops[5]  = {1'b0, 4'h5, 8'h00, 8'h00};
        reg_ops[6]  = {1'b0, 4'h6, 8'h00, 8'h00};
        // bitmap base, odd byte address loses bit 0
        reg_ops[7]  = {1'b1, 4'h0, 8'h35, 8'h00};
        reg_ops[8]  = {1'b1, 4'h1, 8'h12, 8'h00};
        reg_ops[9]  = {1'b1, 4'h2, 8'h01, 8'h00};
        reg_ops[10] = {1'b1, 4'h3, 8'h00, 8'h00};
        reg_ops[11] = {1'b0, 4'h0, 8'h00, 8'h34};
        reg_ops[12] = {1'b0, 4'h1, 8'h00, 8'h12};
        reg_ops[13] = {1'b0, 4'h2, 8'h00, 8'h01};
        // font base, bits above 18 are dropped
        reg_ops[14] = {1'b1, 4'h4, 8'h57, 8'h00};
        reg_ops[15] = {1'b1, 4'h5, 8'hAB, 8'h00};
        reg_ops[16] = {1'b1, 4'h6, 8'hFF, 8'h00};
        reg_ops[17] = {1'b1, 4'h7, 8'h00, 8'h00};
        reg_ops[18] = {1'b0, 4'h4, 8'h00, 8'h56};
        reg_ops[19] = {1'b0, 4'h5, 8'h00, 8'hAB};
        reg_ops[20] = {1'b0, 4'h6, 8'h00, 8'h07};
        reg_ops[21] = {1'b0, 4'h0, 8'h00, 8'h34};
        // palette staging
        reg_ops[22] = {1'b1, 4'h8, 8'h11, 8'h00};
        reg_ops[23] = {1'b1, 4'h9, 8'h22, 8'h00};
        reg_ops[24] = {1'b1, 4'hA, 8'h33, 8'h00};
        reg_ops[25] = {1'b1, 4'hB, 8'h05, 8'h00};
        reg_ops[26] = {1'b0, 4'h8, 8'h00, 8'h11};
        reg_ops[27] = {1'b0, 4'h9, 8'h00, 8'h22};
        reg_ops[28] = {1'b0, 4'hA, 8'h00, 8'h33};
        reg_ops[29] = {1'b0, 4'hB, 8'h00, 8'h05};
        // mode keeps two bits
        reg_ops[30] = {1'b1, 4'hF, 8'hFE, 8'h00};
        reg_ops[31] = {1'b0, 4'hF, 8'h00, 8'h02};
        reg_ops[32] = {1'b1, 4'hF, 8'h01, 8'h00};
        reg_ops[33] = {1'b0, 4'hF, 8'h00, 8'h01};
        reg_ops[34] = {1'b1, 4'hF, 8'h00, 8'h00};
        reg_ops[35] = {1'b0, 4'hF, 8'h00, 8'h00};
        reg_ops[36] = {1'b0, 4'h3, 8'h00, 8'h00};
        reg_ops[37] = {1'b0, 4'h7, 8'h00, 8'h00};
        frames[0] = {MODE_GRAPHICS_640, 18'h00100};
        frames[1] = {MODE_GRAPHICS_320, 18'h2A5C3};
        frames[2] = {MODE_TEXT_40, 18'h00040};
        for (i = 0; i < 256; i++) begin
            ram_words[i] = 16'(random_bits(16));
        end
    endtask

    initial begin : main_flow
        int f;
        int k;
        int errs;
        int exp_row;
        logic [7:0] rd;
        logic [7:0] row_lo;
        logic [7:0] row_hi;
        logic [7:0] vis;
        logic [9:0] row;
        logic [23:0] colour;
        logic [15:0] word;
        I_reset  = 1'b1;
        I_wb_adr = '0;
        I_wb_dat = '0;
        I_wb_stb = 1'b0;
        I_wb_we  = 1'b0;
        I_ram_dat = '0;
        fill_tables();
        repeat (5) @(posedge I_wb_clk);
        I_reset <= 1'b0;
        @(posedge I_wb_clk);

        errs = errors;
        check_frame(MODE_OFF, RAM_BASE_RESET);
        run_reg_ops(0, 6);
        finish_test("reset state", errs);

        errs = errors;
        run_reg_ops(7, NUM_OPS - 1);
        finish_test("register readback", errs);

        load_palette();
        for (f = 0; f < NUM_FRAMES; f++) begin
            errs = errors;
            set_frame(frames[f].mode, frames[f].base);
            check_frame(frames[f].mode, frames[f].base);
            finish_test($sformatf("frame mode %0d base %h", frames[f].mode, frames[f].base),
                        errs);
        end

        // two entries shown at the start of line 0 get one new colour
        errs = errors;
        colour = random_bits(24);
        word = ram_word(frames[0].base);
        stage_colour(colour);
        bus_cycle(1'b1, 4'hB, word[7:0], rd);
        bus_cycle(1'b1, 4'hB, word[15:8], rd);
        pal_model[word[7:0]] = colour;
        pal_model[word[15:8]] = colour;
        set_frame(frames[0].mode, frames[0].base);
        check_frame(frames[0].mode, frames[0].base);
        finish_test("back to back palette updates", errs);

        // k-th line start after vsync ends is row 11 + k, modulo the total
        errs = errors;
        wait_sync_fall(1'b1);
        for (k = 1; k <= V_TOTAL; k++) begin
            wait_sync_fall(1'b0);
            bus_cycle(1'b0, 4'hC, 8'h00, row_lo);
            bus_cycle(1'b0, 4'hD, 8'h00, row_hi);
            bus_cycle(1'b0, 4'hE, 8'h00, vis);
            row = {row_hi[1:0], row_lo};
            exp_row = (V_VISIBLE + V_FRONT + V_SYNC + k) % V_TOTAL;
            compare("row from C/D", row, exp_row);
            compare("row below total", row < V_TOTAL, 1);
            compare("row_visible from E", vis, exp_row < V_VISIBLE);
        end
        finish_test("line status", errs);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
design/vga_pkg.sv
design/vga_ctrl_if.sv
design/vga_wb8_regs.sv
design/vga_timing.sv
design/vga_pixel_fetch.sv
design/vga_palette.sv
design/vga_wb8_extram.sv
bench/tb_vga_wb8_extram.sv
